//--- hdl/cpu_pkg.sv
package cpu_pkg;

    localparam int operand_width = 12; // also the data memory address width.

    typedef enum logic [4:0] {
        ldac   = 5'd3,
        ldiac  = 5'd5,
        stac   = 5'd8,
        mvac   = 5'd9,
        mvacar = 5'd10,
        mvacr1 = 5'd11,
        mvacr2 = 5'd12,
        mvacr3 = 5'd13,
        mvacr4 = 5'd14,
        mvr1ac = 5'd15,
        mvr2ac = 5'd16,
        mvr3ac = 5'd17,
        mvr4ac = 5'd18,
        add    = 5'd19,
        mult   = 5'd20,
        lshift = 5'd21,
        sub    = 5'd22,
        inac   = 5'd23,
        jpnz   = 5'd24,
        stiac  = 5'd25,
        nop    = 5'd28,
        clac   = 5'd30,
        endop  = 5'd31
    } opcode_t;

    // one instruction memory word.
    typedef struct packed {
        opcode_t                  opcode;
        logic [operand_width-1:0] operand;
    } instr_t;

    typedef enum logic [2:0] {idle, fetch, decode, mem_wait, execute, halt} core_state_t;

    typedef enum logic [2:0] {
        alu_pass, alu_add, alu_sub, alu_mult, alu_shl, alu_inc, alu_clear
    } alu_op_t;

endpackage

//--- hdl/instr_mem.sv
`timescale 1ns/10ps

module instr_mem #(
    parameter int imem_addr_width = 11
) (
    input  logic                       clk,
    input  logic                       prog_we_i,
    input  logic [imem_addr_width-1:0] prog_addr_i,
    input  cpu_pkg::instr_t            prog_data_i,
    input  logic [imem_addr_width-1:0] addr_i,
    output cpu_pkg::instr_t            instr_o
);
    import cpu_pkg::*;

    instr_t mem [2**imem_addr_width];

    // empty words decode as opcode 0, which runs as nop.
    initial begin
        for (int i = 0; i < 2**imem_addr_width; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (prog_we_i) begin
            mem[prog_addr_i] <= prog_data_i; // host program load.
        end
        instr_o <= mem[addr_i];
    end

endmodule

//--- hdl/data_mem.sv
`timescale 1ns/10ps

module data_mem #(
    parameter int data_width = 16
) (
    input  logic                               clk,
    input  logic                               a_we_i,
    input  logic [cpu_pkg::operand_width-1:0]  a_addr_i,
    input  logic [data_width-1:0]              a_wdata_i,
    output logic [data_width-1:0]              a_rdata_o,
    input  logic                               b_we_i,
    input  logic [cpu_pkg::operand_width-1:0]  b_addr_i,
    input  logic [data_width-1:0]              b_wdata_i,
    output logic [data_width-1:0]              b_rdata_o
);
    import cpu_pkg::*;

    logic [data_width-1:0] mem [2**operand_width];

    initial begin
        for (int i = 0; i < 2**operand_width; i++) begin
            mem[i] = '0;
        end
    end

    // port a serves the core, port b the host.
    always_ff @(posedge clk) begin
        if (a_we_i) begin
            mem[a_addr_i] <= a_wdata_i;
        end
        if (b_we_i) begin
            mem[b_addr_i] <= b_wdata_i;
        end
        a_rdata_o <= mem[a_addr_i]; // old data on a same-cycle write.
        b_rdata_o <= mem[b_addr_i];
    end

endmodule

//--- hdl/alu.sv
`timescale 1ns/10ps

module alu #(
    parameter int data_width = 16
) (
    input  cpu_pkg::alu_op_t       op_i,
    input  logic [data_width-1:0]  ac_i,
    input  logic [data_width-1:0]  r_i,
    output logic [data_width-1:0]  result_o,
    output logic                   zero_o
);
    import cpu_pkg::*;

    always_comb begin
        case (op_i)
            alu_add: begin
                result_o = ac_i + r_i;
            end
            alu_sub: begin
                result_o = ac_i - r_i;
            end
            alu_mult: begin
                result_o = ac_i * r_i; // low half only.
            end
            alu_shl: begin
                result_o = {ac_i[data_width-2:0], 1'b0};
            end
            alu_inc: begin
                result_o = ac_i + 1'b1;
            end
            alu_clear: begin
                result_o = '0;
            end
            default: begin
                result_o = ac_i; // pass.
            end
        endcase
    end

    // flag on the accumulator itself, used by jpnz.
    assign zero_o = (ac_i == '0);

endmodule

//--- hdl/cpu_core.sv
`timescale 1ns/10ps

module cpu_core #(
    parameter int data_width      = 16,
    parameter int imem_addr_width = 11
) (
    input  logic                               clk,
    input  logic                               reset_i,
    input  logic                               start_i,
    output logic                               busy_o,
    output logic                               done_o,
    output logic [imem_addr_width-1:0]         imem_addr_o,
    input  cpu_pkg::instr_t                    instr_i,
    output logic [cpu_pkg::operand_width-1:0]  dmem_addr_o,
    output logic                               dmem_we_o,
    output logic [data_width-1:0]              dmem_wdata_o,
    input  logic [data_width-1:0]              dmem_rdata_i
);
    import cpu_pkg::*;

    core_state_t                state;
    logic [imem_addr_width-1:0] pc;
    instr_t                     ir;
    logic [data_width-1:0]      ac;
    logic [data_width-1:0]      r;
    logic [data_width-1:0]      ar;
    logic [data_width-1:0]      rf [4]; // r1 to r4.
    alu_op_t                    alu_op;
    logic [data_width-1:0]      alu_result;
    logic                       alu_zero;
    logic                       start_ok;
    logic                       in_exec;

    assign start_ok = start_i && (state == idle || state == halt);
    assign in_exec  = (state == execute);

    assign busy_o      = (state != idle) && (state != halt);
    assign done_o      = (state == halt);
    assign imem_addr_o = pc;

    // direct forms use the operand, indirect forms the low bits of ar.
    assign dmem_addr_o  = (ir.opcode == ldiac || ir.opcode == stiac) ?
                          ir.operand : ar[operand_width-1:0];
    assign dmem_we_o    = in_exec && (ir.opcode == stac || ir.opcode == stiac);
    assign dmem_wdata_o = ac;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= idle;
            pc    <= '0;
        end else begin
            case (state)
                idle, halt: begin
                    if (start_ok) begin
                        state <= fetch;
                        pc    <= '0;
                    end
                end
                fetch: state <= decode; // address goes out this cycle.
                decode: begin
                    if (instr_i.opcode == ldac || instr_i.opcode == ldiac) begin
                        state <= mem_wait;
                    end else begin
                        state <= execute;
                    end
                end
                mem_wait: state <= execute;
                execute: begin
                    if (ir.opcode == endop) begin
                        state <= halt;
                    end else begin
                        state <= fetch;
                    end
                    if (ir.opcode == jpnz && !alu_zero) begin
                        pc <= imem_addr_width'(ir.operand);
                    end else begin
                        pc <= pc + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == decode) begin
            ir <= instr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            ac <= '0;
            r  <= '0;
            ar <= '0;
            for (int i = 0; i < 4; i++) begin
                rf[i] <= '0;
            end
        end else if (in_exec) begin
            case (ir.opcode)
                ldac, ldiac: ac <= dmem_rdata_i; // read issued in mem_wait.
                mvac:        r <= ac;
                mvacar:      ar <= ac;
                mvacr1:      rf[0] <= ac;
                mvacr2:      rf[1] <= ac;
                mvacr3:      rf[2] <= ac;
                mvacr4:      rf[3] <= ac;
                mvr1ac:      ac <= rf[0];
                mvr2ac:      ac <= rf[1];
                mvr3ac:      ac <= rf[2];
                mvr4ac:      ac <= rf[3];
                add, sub, mult, lshift, inac, clac: ac <= alu_result;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (ir.opcode)
            add:     alu_op = alu_add;
            sub:     alu_op = alu_sub;
            mult:    alu_op = alu_mult;
            lshift:  alu_op = alu_shl;
            inac:    alu_op = alu_inc;
            clac:    alu_op = alu_clear;
            default: alu_op = alu_pass;
        endcase
    end

    alu #(
        .data_width(data_width)
    ) alu_i (
        .op_i    (alu_op),
        .ac_i    (ac),
        .r_i     (r),
        .result_o(alu_result),
        .zero_o  (alu_zero)
    );

endmodule

//--- hdl/accel_top.sv
`timescale 1ns/10ps

module accel_top #(
    parameter int data_width      = 16,
    parameter int imem_addr_width = 11
) (
    input  logic                               clk,
    input  logic                               reset_i,
    input  logic                               start_i,
    output logic                               busy_o,
    output logic                               done_o,
    input  logic                               prog_we_i,
    input  logic [imem_addr_width-1:0]         prog_addr_i,
    input  cpu_pkg::instr_t                    prog_data_i,
    input  logic                               host_we_i,
    input  logic [cpu_pkg::operand_width-1:0]  host_addr_i,
    input  logic [data_width-1:0]              host_wdata_i,
    output logic [data_width-1:0]              host_rdata_o
);
    import cpu_pkg::*;

    logic [imem_addr_width-1:0] imem_addr;
    instr_t                     instr;
    logic [operand_width-1:0]   dmem_addr;
    logic                       dmem_we;
    logic [data_width-1:0]      dmem_wdata;
    logic [data_width-1:0]      dmem_rdata;

    cpu_core #(
        .data_width     (data_width),
        .imem_addr_width(imem_addr_width)
    ) cpu_core_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (start_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .imem_addr_o (imem_addr),
        .instr_i     (instr),
        .dmem_addr_o (dmem_addr),
        .dmem_we_o   (dmem_we),
        .dmem_wdata_o(dmem_wdata),
        .dmem_rdata_i(dmem_rdata)
    );

    instr_mem #(
        .imem_addr_width(imem_addr_width)
    ) instr_mem_i (
        .clk        (clk),
        .prog_we_i  (prog_we_i),
        .prog_addr_i(prog_addr_i),
        .prog_data_i(prog_data_i),
        .addr_i     (imem_addr),
        .instr_o    (instr)
    );

    data_mem #(
        .data_width(data_width)
    ) data_mem_i (
        .clk      (clk),
        .a_we_i   (dmem_we),
        .a_addr_i (dmem_addr),
        .a_wdata_i(dmem_wdata),
        .a_rdata_o(dmem_rdata),
        .b_we_i   (host_we_i),
        .b_addr_i (host_addr_i),
        .b_wdata_i(host_wdata_i),
        .b_rdata_o(host_rdata_o)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int half_period = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(half_period) clk_o = ~clk_o; // 40 ns period.

endmodule

//--- test/cpu_model.svh
`ifndef cpu_model_svh
`define cpu_model_svh

// galois lfsr, one step per returned bit.
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        value = {value[30:0], lfsr_state[0]};
        if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'ha300_0000;
        end else begin
            lfsr_state = lfsr_state >> 1;
        end
    end
    return value;
endfunction

// instruction set model, runs prog_img against exp_mem until endop.
task automatic run_model();
    logic [data_width-1:0]      ac;
    logic [data_width-1:0]      r;
    logic [data_width-1:0]      ar;
    logic [data_width-1:0]      rn [4];
    logic [imem_addr_width-1:0] pc;
    logic [16:0]                word;
    int                         steps;
    bit                         halted;
    ac = '0;
    r = '0;
    ar = '0;
    rn = '{default: '0};
    pc = '0;
    steps = 0;
    halted = 1'b0;
    while (!halted && steps < model_step_limit) begin
        word = prog_img[pc];
        pc = pc + 1'b1;
        steps++;
        case (word[16:12])
            5'd3: ac = exp_mem[ar[11:0]];         // ldac.
            5'd5: ac = exp_mem[word[11:0]];       // ldiac.
            5'd8: exp_mem[ar[11:0]] = ac;         // stac.
            5'd25: exp_mem[word[11:0]] = ac;      // stiac.
            5'd9: r = ac;
            5'd10: ar = ac;
            5'd11, 5'd12, 5'd13, 5'd14: rn[int'(word[16:12]) - 11] = ac;
            5'd15, 5'd16, 5'd17, 5'd18: ac = rn[int'(word[16:12]) - 15];
            5'd19: ac = ac + r;
            5'd20: ac = ac * r;                   // low bits only.
            5'd21: ac = ac << 1;
            5'd22: ac = ac - r;
            5'd23: ac = ac + 1'b1;
            5'd24: begin
                if (ac != '0) begin
                    pc = word[imem_addr_width-1:0];
                end
            end
            5'd30: ac = '0;
            5'd31: halted = 1'b1;
            default: ;                            // nop and unused codes.
        endcase
    end
endtask

`endif

//--- test/accel_tb.sv
`timescale 1ns/10ps

module accel_tb;
    import cpu_pkg::*;

    localparam int data_width       = 16;
    localparam int imem_addr_width  = 11;
    localparam int done_timeout     = 20000;
    localparam int model_step_limit = 10000;

    logic                       clk;
    logic                       reset_i;
    logic                       start_i;
    logic                       busy_o;
    logic                       done_o;
    logic                       prog_we_i;
    logic [imem_addr_width-1:0] prog_addr_i;
    logic [16:0]                prog_data_i;
    logic                       host_we_i;
    logic [11:0]                host_addr_i;
    logic [data_width-1:0]      host_wdata_i;
    logic [data_width-1:0]      host_rdata_o;

    logic [16:0]           prog_img [2**imem_addr_width];
    logic [data_width-1:0] exp_mem [4096]; // expected data memory image.
    int                    prog_len;
    logic [31:0]           lfsr_state = 32'h7134;
    int                    error_count;
    int                    timeout_count;
    logic [4:0]            straight_ops [16] = '{ldiac, mvac, mvacr1, mvacr2, mvacr3, mvacr4,
        mvr1ac, mvr2ac, mvr3ac, mvr4ac, add, sub, mult, lshift, inac, stiac};

    `include "cpu_model.svh"

    tb_clock clock_i (.clk_o(clk));

    accel_top #(
        .data_width     (data_width),
        .imem_addr_width(imem_addr_width)
    ) accel_top_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (start_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .host_we_i   (host_we_i),
        .host_addr_i (host_addr_i),
        .host_wdata_i(host_wdata_i),
        .host_rdata_o(host_rdata_o)
    );

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] got);
        $display("Error: %s expected %h got %h", name, exp, got);
        error_count++;
    endtask

    task automatic end_test();
        $display("Errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic write_data(input logic [11:0] addr, input logic [data_width-1:0] value);
        @(posedge clk);
        #2;
        host_we_i = 1'b1;
        host_addr_i = addr;
        host_wdata_i = value;
        @(posedge clk); // word is written on this edge.
        #2;
        host_we_i = 1'b0;
        exp_mem[addr] = value;
    endtask

    task automatic read_data(input logic [11:0] addr, output logic [data_width-1:0] value);
        @(posedge clk);
        #2;
        host_addr_i = addr;
        @(posedge clk);
        #1;
        value = host_rdata_o;
    endtask

    task automatic emit(input logic [4:0] op, input logic [11:0] operand);
        prog_img[prog_len] = {op, operand};
        prog_len++;
    endtask

    // low words hold small values so that index arithmetic stays near them.
    task automatic init_data();
        logic [data_width-1:0] got;
        for (int a = 0; a < 64; a++) begin
            write_data(12'(a), (a < 32) ? 16'(rand_bits(6)) : 16'(rand_bits(16)));
        end
        for (int a = 0; a < 64; a++) begin
            read_data(12'(a), got);
            if (got !== exp_mem[a]) begin
                report_mismatch($sformatf("host_rdata_o[%03h]", a), exp_mem[a], got);
            end
        end
    endtask

    task automatic straight_program();
        int n;
        prog_len = 0;
        n = 8 + int'(rand_bits(4));
        for (int i = 0; i < n; i++) begin
            if (rand_bits(3) == 0) begin
                emit(clac, 12'(rand_bits(7)));
            end else begin
                emit(straight_ops[4'(rand_bits(4))], 12'(rand_bits(7)));
            end
        end
        emit(endop, 12'd0);
    endtask

    task automatic indirect_program();
        prog_len = 0;
        for (int b = 0; b < 4; b++) begin
            emit(ldiac, 12'(rand_bits(5))); // index = 2 * mem[i] + mem[j].
            emit(lshift, 12'd0);
            emit(mvac, 12'd0);
            emit(ldiac, 12'(rand_bits(5)));
            emit(add, 12'd0);
            emit(mvacar, 12'd0);
            if (rand_bits(1) == 1) begin
                emit(ldac, 12'd0);
                emit(stiac, 12'd64 + 12'(rand_bits(6)));
            end else begin
                emit(ldiac, 12'(rand_bits(6)));
                emit(stac, 12'd0);
            end
        end
        emit(endop, 12'd0);
    endtask

    task automatic loop_program();
        logic [11:0] cnt_addr;
        logic [11:0] acc_addr;
        logic [11:0] val_addr;
        cnt_addr = 12'd96 + 12'(rand_bits(3));
        acc_addr = 12'd112 + 12'(rand_bits(3));
        val_addr = 12'(rand_bits(6));
        write_data(cnt_addr, 16'(rand_bits(4) % 15 + 1));
        prog_len = 0;
        emit(clac, 12'd0);
        emit(stiac, acc_addr);
        emit(ldiac, cnt_addr);
        emit(mvacr1, 12'd0);
        emit(ldiac, val_addr); // loop body starts at word 4.
        emit(mvac, 12'd0);
        emit(ldiac, acc_addr);
        emit(add, 12'd0);
        emit(inac, 12'd0);
        emit(stiac, acc_addr);
        emit(clac, 12'd0);
        emit(inac, 12'd0);
        emit(mvac, 12'd0);
        emit(mvr1ac, 12'd0);
        emit(sub, 12'd0);
        emit(mvacr1, 12'd0);
        emit(jpnz, 12'd4);
        emit(endop, 12'd0);
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            #2;
            prog_we_i = 1'b1;
            prog_addr_i = imem_addr_width'(i);
            prog_data_i = prog_img[i];
        end
        @(posedge clk);
        #2;
        prog_we_i = 1'b0;
    endtask

    task automatic start_run();
        @(posedge clk);
        #2;
        start_i = 1'b1;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        if (busy_o !== 1'b1) begin
            report_mismatch("busy_o", 16'h1, 16'(busy_o));
        end
        if (done_o !== 1'b0) begin
            report_mismatch("done_o", 16'h0, 16'(done_o));
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done_o !== 1'b1 && cycles < done_timeout) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (done_o !== 1'b1) begin
            $display("Timeout: the core did not raise done_o within %0d cycles", done_timeout);
            timeout_count++;
        end
    endtask

    task automatic compare_memory();
        logic [data_width-1:0] got;
        for (int a = 0; a < 4096; a++) begin
            read_data(12'(a), got);
            if (got !== exp_mem[a]) begin
                report_mismatch($sformatf("host_rdata_o[%03h]", a), exp_mem[a], got);
            end
        end
    endtask

    task automatic run_test(input int kind);
        init_data();
        case (kind)
            0: straight_program();
            1: indirect_program();
            default: loop_program();
        endcase
        load_program();
        run_model();
        start_run();
        wait_done();
        if (timeout_count == 0) begin
            if (busy_o !== 1'b0) begin
                report_mismatch("busy_o", 16'h0, 16'(busy_o));
            end
            compare_memory();
        end
    endtask

    initial begin
        reset_i = 1'b1;
        start_i = 1'b0;
        prog_we_i = 1'b0;
        prog_addr_i = '0;
        prog_data_i = '0;
        host_we_i = 1'b0;
        host_addr_i = '0;
        host_wdata_i = '0;
        error_count = 0;
        timeout_count = 0;
        prog_len = 0;
        prog_img = '{default: '0}; // both memories start out cleared.
        exp_mem = '{default: '0};
        repeat (5) @(posedge clk);
        #2;
        reset_i = 1'b0;
        if (busy_o !== 1'b0) begin
            report_mismatch("busy_o", 16'h0, 16'(busy_o));
        end
        if (done_o !== 1'b0) begin
            report_mismatch("done_o", 16'h0, 16'(done_o));
        end
        for (int i = 0; i < 4 && timeout_count == 0; i++) begin
            run_test(0);
        end
        for (int i = 0; i < 3 && timeout_count == 0; i++) begin
            run_test(1);
        end
        for (int i = 0; i < 3 && timeout_count == 0; i++) begin
            run_test(2);
        end
        end_test();
    end

endmodule

//--- accel_top.f
+incdir+test
hdl/cpu_pkg.sv
hdl/instr_mem.sv
hdl/data_mem.sv
hdl/alu.sv
hdl/cpu_core.sv
hdl/accel_top.sv
test/tb_clock.sv
test/accel_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the accel_top testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -Wno-fatal --top-module accel_tb -f accel_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vaccel_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
